//--- hw/downsampler.sv
// --------------------------------------------------------------------------
//  Downsampler
//  Decimation by an integer factor. Passes the strobe of every M-th
//  filter output, starting with the first one after reset.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module downsampler (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  en_i,
    input  logic                                  tvalid_i,
    input  logic [resampler_pkg::ratio_width-1:0] decim_i,
    output logic                                  tvalid_o
);

    logic [resampler_pkg::ratio_width-1:0] phase;
    logic [resampler_pkg::ratio_width-1:0] last_phase;

    assign last_phase = (decim_i == '0) ? '0 : decim_i - 1'b1; // 0 acts as 1.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase <= '0;
        end else if (en_i && tvalid_i) begin
            if (phase >= last_phase) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // purely gating, data goes around this stage.
    assign tvalid_o = tvalid_i && (phase == '0);

endmodule

//--- hw/resampler.sv
// --------------------------------------------------------------------------
//  Multichannel sample-rate converter
//  Upsampler, shared FIR, downsampler and rounder in one pipeline with a
//  global enable. Integer interpolation and decimation factors.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module resampler (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  en_i,
    input  resampler_pkg::round_mode_e            round_mode_i,
    input  logic [resampler_pkg::ratio_width-1:0] interp_i,
    input  logic [resampler_pkg::ratio_width-1:0] decim_i,
    input  logic                                  s_tvalid_i,
    input  resampler_pkg::sample_t                s_tdata_i,
    output logic                                  s_tready_o,
    output logic                                  m_tvalid_o,
    output resampler_pkg::sample_t                m_tdata_o,
    output logic                                  sat_o
);

    logic                   up_valid;
    resampler_pkg::sample_t up_data;
    logic                   fir_valid;
    resampler_pkg::acc_t    fir_data;
    logic                   dec_valid;

    upsampler upsampler_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .interp_i  (interp_i),
        .s_tvalid_i(s_tvalid_i),
        .s_tdata_i (s_tdata_i),
        .s_tready_o(s_tready_o),
        .tvalid_o  (up_valid),
        .tdata_o   (up_data)
    );

    sfir sfir_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (en_i),
        .tvalid_i(up_valid),
        .tdata_i (up_data),
        .tvalid_o(fir_valid),
        .tdata_o (fir_data)
    );

    downsampler downsampler_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (en_i),
        .tvalid_i(fir_valid),
        .decim_i (decim_i),
        .tvalid_o(dec_valid)
    );

    // rounder takes the filter data directly, only the strobe is decimated.
    sat_round sat_round_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .tvalid_i    (dec_valid),
        .round_mode_i(round_mode_i),
        .tdata_i     (fir_data),
        .tvalid_o    (m_tvalid_o),
        .tdata_o     (m_tdata_o),
        .sat_o       (sat_o)
    );

endmodule

//--- hw/resampler_pkg.sv
// --------------------------------------------------------------------------
//  Resampler shared definitions
//  Sample and filter widths, the factor port width, the lowpass coefficient
//  table and the bundle types that travel between the pipeline stages.
// --------------------------------------------------------------------------

package resampler_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int ch_num      = 2;                       // parallel channels.
    localparam int data_width  = 16;                      // signed sample.
    localparam int coef_width  = 18;                      // signed q1.17.
    localparam int tap_num     = 16;
    localparam int fir_width   = data_width + coef_width; // full product width.
    localparam int coef_frac   = 17;                      // bits removed by the rounder.
    localparam int ratio_width = 4;                       // factors 1..15, 0 acts as 1.

    // ------------------------------------------------------------------------
    // coefficients
    // ------------------------------------------------------------------------
    // Symmetric lowpass. The taps add up to exactly 1.0 so DC passes at unit
    // gain, while the negative side lobes let a sign-matched full scale input
    // push the sum past the sample range.
    localparam logic signed [coef_width-1:0] coef_table [tap_num] = '{
        -18'sd512,
        -18'sd1024,
        -18'sd1536,
        18'sd0,
        18'sd4096,
        18'sd12288,
        18'sd20480,
        18'sd31744,
        18'sd31744,
        18'sd20480,
        18'sd12288,
        18'sd4096,
        18'sd0,
        -18'sd1536,
        -18'sd1024,
        -18'sd512
    };

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------
    typedef logic signed [ch_num-1:0][data_width-1:0] sample_t; // one sample per channel.
    typedef logic signed [ch_num-1:0][fir_width-1:0]  acc_t;    // one filter sum per channel.

    typedef enum logic [1:0] {
        round_trunc   = 2'd0, // floor.
        round_nearest = 2'd1, // nearest, ties away from zero.
        round_zero    = 2'd2  // toward zero.
    } round_mode_e;

endpackage

//--- hw/sat_round.sv
// --------------------------------------------------------------------------
//  Rounder and saturator
//  Drops the coefficient fraction bits from each filter sum with the
//  selected rounding mode, clamps to the sample range and flags clipping.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module sat_round (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       en_i,
    input  logic                       tvalid_i,
    input  resampler_pkg::round_mode_e round_mode_i,
    input  resampler_pkg::acc_t        tdata_i,
    output logic                       tvalid_o,
    output resampler_pkg::sample_t     tdata_o,
    output logic                       sat_o
);

    resampler_pkg::sample_t            rnd;
    logic [resampler_pkg::ch_num-1:0]  ch_sat;

    for (genvar c = 0; c < resampler_pkg::ch_num; c++) begin : g_ch
        logic signed [resampler_pkg::fir_width-1:0]  x;
        logic signed [resampler_pkg::fir_width-1:0]  q;
        logic signed [resampler_pkg::fir_width-1:0]  r;
        logic [resampler_pkg::coef_frac-1:0]         frac;
        logic [resampler_pkg::fir_width-resampler_pkg::data_width:0] top;
        logic                                        neg;
        logic                                        inc;

        assign x    = $signed(tdata_i[c]);
        assign frac = x[resampler_pkg::coef_frac-1:0];
        assign neg  = x[resampler_pkg::fir_width-1];
        assign q    = x >>> resampler_pkg::coef_frac; // floor.

        // step up from the floor where the mode asks for it.
        always_comb begin
            case (round_mode_i)
                resampler_pkg::round_nearest: begin
                    // above half always, exactly half only for positives.
                    inc = frac[resampler_pkg::coef_frac-1] &&
                          ((|frac[resampler_pkg::coef_frac-2:0]) || !neg);
                end
                resampler_pkg::round_zero: begin
                    inc = neg && (|frac);
                end
                default: begin
                    inc = 1'b0;
                end
            endcase
        end

        assign r = q + $signed({1'b0, inc});

        // in range when all bits above the sample sign match it.
        assign top       = r[resampler_pkg::fir_width-1:resampler_pkg::data_width-1];
        assign ch_sat[c] = !((&top) || !(|top));

        assign rnd[c] = ch_sat[c] ?
            {r[resampler_pkg::fir_width-1], {(resampler_pkg::data_width-1){~r[resampler_pkg::fir_width-1]}}} :
            r[resampler_pkg::data_width-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
            sat_o    <= 1'b0;
        end else if (en_i) begin
            tvalid_o <= tvalid_i;
            sat_o    <= tvalid_i && (|ch_sat); // any channel clipped.
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && tvalid_i) begin
            tdata_o <= rnd;
        end
    end

endmodule

//--- hw/sfir.sv
// --------------------------------------------------------------------------
//  Multichannel FIR
//  Direct-form filter with one delay line per channel and a shared
//  coefficient table. Products are registered, then summed into a
//  registered full-width result, two cycles after the input strobe.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module sfir (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   en_i,
    input  logic                   tvalid_i,
    input  resampler_pkg::sample_t tdata_i,
    output logic                   tvalid_o,
    output resampler_pkg::acc_t    tdata_o
);

    // ------------------------------------------------------------------------
    // delay line
    // ------------------------------------------------------------------------
    // win holds the incoming sample at tap 0 and the stored history behind
    // it, so products of a new item are formed at the same edge it arrives.
    logic signed [resampler_pkg::data_width-1:0]
        dline [resampler_pkg::ch_num][resampler_pkg::tap_num-1];
    logic signed [resampler_pkg::data_width-1:0]
        win   [resampler_pkg::ch_num][resampler_pkg::tap_num];

    always_comb begin
        for (int c = 0; c < resampler_pkg::ch_num; c++) begin
            win[c][0] = $signed(tdata_i[c]);
            for (int k = 1; k < resampler_pkg::tap_num; k++) begin
                win[c][k] = dline[c][k-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int c = 0; c < resampler_pkg::ch_num; c++) begin
                for (int k = 0; k < resampler_pkg::tap_num - 1; k++) begin
                    dline[c][k] <= '0;
                end
            end
        end else if (en_i && tvalid_i) begin
            for (int c = 0; c < resampler_pkg::ch_num; c++) begin
                for (int k = 0; k < resampler_pkg::tap_num - 1; k++) begin
                    dline[c][k] <= win[c][k]; // shift by one tap.
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // multiply
    // ------------------------------------------------------------------------
    logic signed [resampler_pkg::fir_width-1:0]
        prod [resampler_pkg::ch_num][resampler_pkg::tap_num];

    always_ff @(posedge clk_i) begin
        if (en_i && tvalid_i) begin
            for (int c = 0; c < resampler_pkg::ch_num; c++) begin
                for (int k = 0; k < resampler_pkg::tap_num; k++) begin
                    prod[c][k] <= win[c][k] * resampler_pkg::coef_table[k];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // accumulate
    // ------------------------------------------------------------------------
    // worst case sum stays below 2^33, so the full product width suffices.
    logic signed [resampler_pkg::fir_width-1:0] sum_c [resampler_pkg::ch_num];

    always_comb begin
        for (int c = 0; c < resampler_pkg::ch_num; c++) begin
            sum_c[c] = '0;
            for (int k = 0; k < resampler_pkg::tap_num; k++) begin
                sum_c[c] = sum_c[c] + prod[c][k];
            end
        end
    end

    logic [1:0] vld; // one bit per register stage.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld <= '0;
        end else if (en_i) begin
            vld <= {vld[0], tvalid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && vld[0]) begin
            for (int c = 0; c < resampler_pkg::ch_num; c++) begin
                tdata_o[c] <= sum_c[c];
            end
        end
    end

    assign tvalid_o = vld[1];

endmodule

//--- hw/upsampler.sv
// --------------------------------------------------------------------------
//  Upsampler
//  Zero-stuffing interpolation by an integer factor. Each accepted sample
//  is followed by factor-1 zero items, and input ready is held low until
//  the last item of the group is on the output.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module upsampler (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  en_i,
    input  logic [resampler_pkg::ratio_width-1:0] interp_i,
    input  logic                                  s_tvalid_i,
    input  resampler_pkg::sample_t                s_tdata_i,
    output logic                                  s_tready_o,
    output logic                                  tvalid_o,
    output resampler_pkg::sample_t                tdata_o
);

    typedef enum logic {
        st_idle  = 1'b0,
        st_stuff = 1'b1
    } state_e;

    state_e                                state;
    logic [resampler_pkg::ratio_width-1:0] cnt;      // index of the item being emitted.
    logic [resampler_pkg::ratio_width-1:0] last_idx; // last item index of a group.
    logic                                  accept;

    assign last_idx = (interp_i == '0) ? '0 : interp_i - 1'b1;
    assign accept   = s_tvalid_i && s_tready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= st_idle;
            cnt        <= '0;
            s_tready_o <= 1'b0;
            tvalid_o   <= 1'b0;
        end else if (en_i) begin
            unique case (state)
                st_idle: begin
                    tvalid_o <= accept;
                    if (accept && last_idx != '0) begin
                        state      <= st_stuff;
                        cnt        <= 1'b1;
                        s_tready_o <= 1'b0; // hold off until the last zero.
                    end else begin
                        s_tready_o <= 1'b1;
                    end
                end
                st_stuff: begin
                    tvalid_o <= 1'b1;
                    if (cnt >= last_idx) begin
                        state      <= st_idle;
                        cnt        <= '0;
                        s_tready_o <= 1'b1; // next sample may land right behind.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // payload. sample on acceptance, zeros while stuffing.
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (state == st_stuff) begin
                tdata_o <= '0;
            end else if (accept) begin
                tdata_o <= s_tdata_i;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module resampler_tb \
    -f sources.f -Mdir obj_dir
out=$(./obj_dir/Vresampler_tb)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

//--- sources.f
hw/resampler_pkg.sv
hw/upsampler.sv
hw/sfir.sv
hw/downsampler.sv
hw/sat_round.sv
hw/resampler.sv
tests/resampler_sva.sv
tests/resampler_tb.sv

//--- tests/resampler_sva.sv
// --------------------------------------------------------------------------
//  Resampler protocol checks
//  Reset quiet outputs, unit-ratio latency gap and input ready hold-off
//  during zero stuffing. Bound to the top level.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module resampler_sva (
    input logic                                  clk_i,
    input logic                                  rst_i,
    input logic                                  en_i,
    input logic [resampler_pkg::ratio_width-1:0] interp_i,
    input logic [resampler_pkg::ratio_width-1:0] decim_i,
    input logic                                  s_tvalid_i,
    input logic                                  s_tready_o,
    input logic                                  m_tvalid_o
);

    logic                                  accept;
    logic                                  unit_ratio;
    logic [resampler_pkg::ratio_width-1:0] low_cnt; // cycles of ready still owed low.

    assign accept     = s_tvalid_i && s_tready_o && en_i;
    assign unit_ratio = (interp_i <= 1) && (decim_i <= 1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            low_cnt <= '0;
        end else if (accept && interp_i > 1) begin
            low_cnt <= interp_i - 1'b1;
        end else if (en_i && low_cnt != '0) begin
            low_cnt <= low_cnt - 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> !m_tvalid_o && !s_tready_o)
        else $error("outputs active during reset");

    // a lone acceptance leaves the output idle until its own item lands.
    unit_gap: assert property (@(posedge clk_i) disable iff (rst_i)
        accept && unit_ratio && !$past(accept) && !$past(accept, 2) && !$past(accept, 3)
        |-> ##1 !m_tvalid_o ##1 !m_tvalid_o ##1 !m_tvalid_o)
        else $error("output appeared too early after acceptance");

    ready_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        low_cnt != '0 |-> !s_tready_o)
        else $error("input ready rose while zeros were still being stuffed");

endmodule

bind resampler resampler_sva resampler_sva_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (en_i),
    .interp_i  (interp_i),
    .decim_i   (decim_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .m_tvalid_o(m_tvalid_o)
);

//--- tests/resampler_tb.sv
// --------------------------------------------------------------------------
//  Resampler testbench
//  Impulse, interpolation, decimation, rounding, saturation and enable
//  freeze runs against a behavioral model of the converter.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module resampler_tb;

    localparam int clk_period    = 4;
    localparam int total_samples = 24 + 20 + 30 + 20 + 60 + 64 + 30;
    localparam int timeout_ns    = (total_samples * 4 + 8 * 500) * clk_period;

    logic clk_i, rst_i, en_i, s_tvalid_i, s_tready_o, m_tvalid_o, sat_o;
    resampler_pkg::round_mode_e            round_mode_i;
    logic [resampler_pkg::ratio_width-1:0] interp_i, decim_i;
    resampler_pkg::sample_t                s_tdata_i, m_tdata_o, exp_d;

    resampler_pkg::sample_t exp_q[$];
    logic                   exp_sat_q[$];
    logic                   exp_s;
    longint                 hist [resampler_pkg::ch_num][resampler_pkg::tap_num];
    longint                 cyc, accept_cyc, lat_ref, prev_accept;
    int                     errors, out_count, fir_cnt, cur_l, cur_m;
    bit                     check_latency;
    bit                     check_pace;
    logic [31:0]            lcg_state;
    resampler_pkg::round_mode_e cur_mode;

    resampler resampler_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic resampler_pkg::sample_t rand_sample();
        resampler_pkg::sample_t s;
        for (int c = 0; c < resampler_pkg::ch_num; c++) begin
            lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
            s[c] = lcg_state[31:16];
        end
        return s;
    endfunction

    // divide out the fraction; sv division truncates toward zero.
    function automatic longint round_sum(longint s, resampler_pkg::round_mode_e mode);
        longint one;
        longint half;
        one  = longint'(1) << resampler_pkg::coef_frac;
        half = one / 2;
        case (mode)
            resampler_pkg::round_nearest: return (s >= 0) ? (s + half) / one : -((-s + half) / one);
            resampler_pkg::round_zero:    return s / one;
            default:                      return (s >= 0) ? s / one : -((-s + one - 1) / one);
        endcase
    endfunction

    function automatic void model_item(resampler_pkg::sample_t x);
        resampler_pkg::sample_t y;
        longint sum, r;
        logic sat;
        sat = 1'b0;
        for (int c = 0; c < resampler_pkg::ch_num; c++) begin
            for (int k = resampler_pkg::tap_num - 1; k > 0; k--) hist[c][k] = hist[c][k-1];
            hist[c][0] = longint'($signed(x[c]));
            sum = 0;
            for (int k = 0; k < resampler_pkg::tap_num; k++) begin
                sum += hist[c][k] * longint'(resampler_pkg::coef_table[k]);
            end
            r = round_sum(sum, cur_mode);
            if (r > 32767 || r < -32768) sat = 1'b1;
            y[c] = (r > 32767) ? 16'sh7fff : (r < -32768) ? 16'sh8000 : r[15:0];
        end
        if (fir_cnt % cur_m == 0) begin
            exp_q.push_back(y);
            exp_sat_q.push_back(sat);
        end
        fir_cnt++;
    endfunction

    task automatic start_phase(int l, int m, resampler_pkg::round_mode_e mode);
        @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        s_tvalid_i = 1'b0;
        interp_i = l[3:0];
        decim_i = m[3:0];
        round_mode_i = mode;
        cur_l = l;
        cur_m = m;
        cur_mode = mode;
        fir_cnt = 0;
        prev_accept = -1;
        foreach (hist[c, k]) hist[c][k] = 0;
        repeat (8) @(posedge clk_i);
        #1 rst_i = 1'b0;
    endtask

    task automatic send(resampler_pkg::sample_t x);
        int waited;
        waited = 0;
        s_tdata_i = x;
        s_tvalid_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (s_tready_o && en_i) break;
            waited++;
            if (waited > 64) begin
                $display("Input stalled at %0t: s_tready_o never rose", $time);
                errors++;
                break;
            end
            @(posedge clk_i);
            #1;
        end
        accept_cyc = cyc + 1;
        // one input per group of l items.
        if (check_pace && prev_accept >= 0) begin
            assert (accept_cyc - prev_accept == cur_l) else begin
                $display("Mismatch at %0t: inputs taken %0d cycles apart, expected %0d",
                         $time, accept_cyc - prev_accept, cur_l);
                errors++;
            end
        end
        prev_accept = accept_cyc;
        for (int i = 0; i < cur_l; i++) model_item(i == 0 ? x : '0);
        @(posedge clk_i);
        #1 s_tvalid_i = 1'b0;
    endtask

    task automatic drain(string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 400) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (10) @(negedge clk_i);
        assert (exp_q.size() == 0) else begin
            $display("%s run: %0d expected outputs never arrived", name, exp_q.size());
            errors++;
        end
    endtask

    // output is consumed at the edge where en_i is high.
    always @(negedge clk_i) begin
        if (!rst_i && en_i && m_tvalid_o) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Unexpected output at %0t with nothing pending", $time);
                errors++;
            end else begin
                exp_d = exp_q.pop_front();
                exp_s = exp_sat_q.pop_front();
                assert (m_tdata_o === exp_d && sat_o === exp_s) else begin
                    $display("Mismatch at %0t: got %h sat %b, expected %h sat %b",
                             $time, m_tdata_o, sat_o, exp_d, exp_s);
                    errors++;
                end
                if (check_latency) begin
                    assert (cyc + 1 - lat_ref == 4) else begin
                        $display("Mismatch at %0t: latency %0d cycles, expected 4",
                                 $time, cyc + 1 - lat_ref);
                        errors++;
                    end
                    check_latency = 0;
                end
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the run did not finish", timeout_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        resampler_pkg::sample_t imp, v;
        logic [31:0] saved;
        logic held;
        rst_i = 1'b1;
        en_i = 1'b1;
        s_tvalid_i = 1'b0;
        s_tdata_i = '0;
        interp_i = 4'd1;
        decim_i = 4'd1;
        round_mode_i = resampler_pkg::round_trunc;
        errors = 0;
        out_count = 0;
        cyc = 0;
        check_latency = 0;
        check_pace = 1;
        prev_accept = -1;
        lcg_state = 32'hd97dff5f;

        // impulse at half scale.
        start_phase(1, 1, resampler_pkg::round_nearest);
        imp[0] = 16'sd16384;
        imp[1] = 16'sd16384;
        send(imp);
        lat_ref = accept_cyc;
        check_latency = 1;
        repeat (23) send('0);
        drain("impulse");

        start_phase(4, 1, resampler_pkg::round_nearest);
        repeat (20) send(rand_sample());
        drain("interpolation");

        start_phase(1, 3, resampler_pkg::round_nearest);
        repeat (30) send(rand_sample());
        drain("decimation");
        start_phase(3, 2, resampler_pkg::round_trunc);
        repeat (20) send(rand_sample());
        drain("combined");

        // same stream through each rounding mode.
        saved = lcg_state;
        for (int m = 0; m < 3; m++) begin
            lcg_state = saved;
            start_phase(2, 1, resampler_pkg::round_mode_e'(m));
            repeat (20) send(rand_sample());
            drain("rounding");
        end

        // signs matched to the taps push the sum past full scale.
        start_phase(1, 1, resampler_pkg::round_nearest);
        for (int rep = 0; rep < 4; rep++) begin
            for (int j = 0; j < resampler_pkg::tap_num; j++) begin
                held = (resampler_pkg::coef_table[15-j] < 0) ^ rep[0];
                v[0] = held ? 16'sh8000 : 16'sh7fff;
                v[1] = held ? 16'sh7fff : 16'sh8000;
                send(v);
            end
        end
        drain("saturation");

        // the freeze stretches the gap between inputs.
        check_pace = 0;
        start_phase(2, 1, resampler_pkg::round_zero);
        fork
            repeat (30) send(rand_sample());
            begin
                repeat (12) @(posedge clk_i);
                #1 en_i = 1'b0;
                @(negedge clk_i);
                held = s_tready_o;
                repeat (5) begin
                    @(negedge clk_i);
                    assert (s_tready_o === held) else begin
                        $display("s_tready_o changed at %0t while en_i was low", $time);
                        errors++;
                    end
                end
                @(posedge clk_i);
                #1 en_i = 1'b1;
            end
        join
        drain("freeze");

        $display("Errors: %0d, outputs checked: %0d", errors, out_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
